// ==== files.f ====
design/cpuPkg.sv
design/alu.sv
design/regFile.sv
design/interruptCtrl.sv
design/control.sv
design/cpu.sv
design/memorySystem.sv
design/mcuTop.sv
tests/mcu_properties.sv
tests/mcuChecker.sv
tests/tbMcu.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tbMcu
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= === PASS ===

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)

// ==== tests/tbMcu.sv ====
`timescale 1ns/1ps

module tbMcu import cpuPkg::*; ();
    logic        clk;
    logic        rst;
    logic        progWrite;
    logic [15:0] progAddr;
    logic [15:0] progData;
    logic [2:0]  irqLines;
    logic [7:0]  outPort;
    logic        outValid;
    logic        halted;

    logic [15:0] prog [256];
    logic [7:0]  progPtr;
    logic [7:0]  expBytes [64];
    int          expCount;
    int          gotCount;
    int          errorCount;
    int          testsRun;
    int          testsFailed;
    integer      seed = 32'hf636ffc6;

    mcuTop #(.iMemDepth(256)) UUT (
        .clk(clk), .rst(rst), .progWrite(progWrite), .progAddr(progAddr),
        .progData(progData), .irqLines(irqLines), .outPort(outPort),
        .outValid(outValid), .halted(halted)
    );

    mcuChecker chk (
        .clk(clk), .rst(rst), .outValid(outValid), .outPort(outPort),
        .expBytes(expBytes), .expCount(expCount),
        .gotCount(gotCount), .errorCount(errorCount)
    );

    always #2 clk = ~clk;

    //**********************************************************
    // Program assembly
    function automatic logic [15:0] encReg(opcodeT op, logic [3:0] rd, logic [3:0] rs);
        return {op, rd, rs, 4'h0};
    endfunction

    function automatic logic [15:0] encImm(opcodeT op, logic [3:0] rd, logic [7:0] imm);
        return {op, rd, imm};
    endfunction

    task automatic put(input logic [15:0] word);
        prog[progPtr] = word;
        progPtr = progPtr + 8'd1;
    endtask

    task automatic clearProg();
        for (int i = 0; i < 256; i++) begin
            prog[8'(i)] = 16'h0000;           // NOP
        end
        progPtr = 8'd0;
    endtask

    task automatic emitByte(input logic [7:0] value);
        put(encImm(opLdi, 4'd1, value));
        put(encImm(opSt, 4'd1, 8'hFF));
    endtask

    // Spin until the ISR sets the flag byte, r6 holds zero
    task automatic flagLoop();
        logic [7:0] loopAt;
        loopAt = progPtr;
        put(encImm(opLd, 4'd5, 8'h20));
        put(encReg(opAdd, 4'd5, 4'd6));
        put(encImm(opJz, 4'd0, loopAt));
    endtask

    task automatic putIsr();
        progPtr = irqVector[7:0];
        put(encImm(opLdi, 4'd7, 8'hA5));    // Marker
        put(encImm(opSt, 4'd7, 8'hFF));
        put(encImm(opLdi, 4'd7, 8'h01));
        put(encImm(opSt, 4'd7, 8'h20));
        put(encImm(opReti, 4'd0, 8'h00));
    endtask

    //**********************************************************
    // Reference model
    function automatic logic [7:0] aluRef(opcodeT op, logic [7:0] a, logic [7:0] b);
        case (op)
            opAdd:   return a + b;
            opSub:   return a - b;
            opAnd:   return a & b;
            opOr:    return a | b;
            default: return a ^ b;
        endcase
    endfunction

    // Runs prog, fills expBytes, returns executed instruction count
    function automatic int runModel(int irqLine, int irqAfter);
        logic [7:0]  regs [16];
        logic [7:0]  dmem [256];
        logic [15:0] pc;
        logic [15:0] ret;
        logic [15:0] word;
        logic        zf;
        logic        ie;
        logic        taken;
        logic        raised;
        logic [2:0]  mask;
        logic [2:0]  pending;
        opcodeT      op;
        logic [3:0]  rd;
        logic [3:0]  rs;
        logic [7:0]  imm;
        int          steps;
        for (int i = 0; i < 16; i++) regs[4'(i)] = 8'd0;
        for (int i = 0; i < 256; i++) dmem[8'(i)] = 8'd0;
        pc = 16'd0;
        ret = 16'd0;
        zf = 1'b0;
        ie = 1'b0;
        raised = 1'b0;
        mask = 3'b111;
        pending = 3'b000;
        steps = 0;
        expCount = 0;
        while (steps < 2000) begin
            if (irqLine >= 0 && !raised && expCount >= irqAfter) begin
                pending[2'(irqLine)] = 1'b1;
                raised = 1'b1;
            end
            // Interrupt entry at an instruction boundary
            if (ie && |(pending & mask)) begin
                taken = 1'b0;
                for (int k = 0; k < 3; k++) begin
                    if (!taken && pending[2'(k)] && mask[2'(k)]) begin
                        pending[2'(k)] = 1'b0;
                        taken = 1'b1;
                    end
                end
                ret = pc;
                ie = 1'b0;
                pc = irqVector;
            end
            word = prog[pc[7:0]];
            op = opcodeT'(word[15:12]);
            rd = word[11:8];
            rs = word[7:4];
            imm = word[7:0];
            pc = pc + 16'd1;
            steps++;
            case (op)
                opAdd, opSub, opAnd, opOr, opXor: begin
                    regs[rd] = aluRef(op, regs[rd], regs[rs]);
                    zf = (regs[rd] == 8'd0);
                end
                opLdi: regs[rd] = imm;
                opLd:  regs[rd] = dmem[imm];
                opSt: begin
                    dmem[imm] = regs[rd];
                    if (imm == 8'hFF) begin
                        expBytes[6'(expCount)] = regs[rd];
                        expCount++;
                    end
                    if (imm == 8'hFE) mask = regs[rd][2:0];
                end
                opJmp: pc = {8'h00, imm};
                opJz: begin
                    if (zf) pc = {8'h00, imm};
                end
                opEi: ie = 1'b1;
                opReti: begin
                    ie = 1'b1;
                    pc = ret;
                end
                opHlt: return steps;
                default: begin
                end
            endcase
        end
        return steps;
    endfunction

    //**********************************************************
    // Test runner
    task automatic runTest(input string name, input int irqLine, input int irqAfter);
        int limit;
        int cycles;
        int hold;
        int errsBefore;
        logic raised;
        logic failed;
        limit = 3 * runModel(irqLine, irqAfter) + 200;
        chk.testName = name;
        errsBefore = errorCount;
        failed = 1'b0;
        @(negedge clk);
        rst = 1'b1;
        irqLines = 3'b000;
        for (int i = 0; i < 256; i++) begin
            @(negedge clk);
            progWrite = 1'b1;
            progAddr = 16'(i);
            progData = prog[8'(i)];
        end
        @(negedge clk);
        progWrite = 1'b0;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        cycles = 0;
        hold = 0;
        raised = 1'b0;
        while (!halted) begin
            @(negedge clk);
            cycles++;
            if (irqLine >= 0 && !raised && gotCount >= irqAfter) begin
                irqLines[2'(irqLine)] = 1'b1;   // Short pulse, edge sets pending
                raised = 1'b1;
                hold = 4;
            end else if (hold > 0) begin
                hold--;
                if (hold == 0) irqLines = 3'b000;
            end
            if (cycles > limit) begin
                $display("Timeout: test %s did not halt within %0d cycles", name, limit);
                $display("=== FAIL ===");
                $finish;
            end
        end
        irqLines = 3'b000;
        repeat (12) @(negedge clk);     // Any stray output after halt shows up here
        if (!halted) begin
            $display("Test %s: halted output dropped after halt", name);
            failed = 1'b1;
        end
        if (gotCount != expCount) begin
            $display("Test %s: saw %0d output bytes, expected %0d", name, gotCount, expCount);
            failed = 1'b1;
        end
        if (errorCount != errsBefore) failed = 1'b1;
        testsRun++;
        if (failed) testsFailed++;
        $display("Test %s: %s", name, failed ? "failed" : "ok");
    endtask

    //**********************************************************
    // Programs
    task automatic buildAlu();
        logic [7:0] a;
        logic [7:0] b;
        clearProg();
        a = 8'($random(seed));
        b = 8'($random(seed));
        put(encImm(opLdi, 4'd2, b));
        for (int k = 1; k <= 5; k++) begin
            put(encImm(opLdi, 4'd3, a));
            put(encReg(opcodeT'(4'(k)), 4'd3, 4'd2));    // ADD through XOR
            put(encImm(opSt, 4'd3, 8'hFF));
        end
        put(encImm(opHlt, 4'd0, 8'h00));
    endtask

    task automatic buildJz();
        logic [7:0] v;
        clearProg();
        v = 8'($random(seed));
        put(encImm(opLdi, 4'd1, v));
        put(encImm(opLdi, 4'd2, v));
        put(encReg(opSub, 4'd1, 4'd2));
        put(encImm(opJz, 4'd0, 8'h08));
        put(encImm(opLdi, 4'd3, 8'h55));
        put(encImm(opSt, 4'd3, 8'hFF));
        put(encImm(opHlt, 4'd0, 8'h00));
        progPtr = 8'h08;                   // Zero branch target
        put(encImm(opLdi, 4'd3, 8'hAA));
        put(encImm(opSt, 4'd3, 8'hFF));
        put(encImm(opLdi, 4'd1, v));
        put(encImm(opLdi, 4'd2, v + 8'd1));
        put(encReg(opSub, 4'd1, 4'd2));
        put(encImm(opJz, 4'd0, 8'h20));
        put(encImm(opLdi, 4'd3, 8'h55));
        put(encImm(opSt, 4'd3, 8'hFF));
        put(encImm(opHlt, 4'd0, 8'h00));
        progPtr = 8'h20;
        put(encImm(opLdi, 4'd3, 8'hEE));
        put(encImm(opSt, 4'd3, 8'hFF));
        put(encImm(opHlt, 4'd0, 8'h00));
    endtask

    task automatic buildMem();
        clearProg();
        for (int k = 0; k < 4; k++) begin
            put(encImm(opLdi, 4'd1, 8'($random(seed))));
            put(encImm(opSt, 4'd1, 8'(8'h30 + k)));
        end
        for (int k = 0; k < 4; k++) begin
            put(encImm(opLd, 4'(4 + k), 8'(8'h30 + k)));
            put(encImm(opSt, 4'(4 + k), 8'hFF));
        end
        put(encImm(opHlt, 4'd0, 8'h00));
    endtask

    task automatic buildIrq();
        clearProg();
        put(encImm(opLdi, 4'd6, 8'h00));
        put(encImm(opSt, 4'd6, 8'h20));    // Clear ISR flag
        put(encImm(opEi, 4'd0, 8'h00));
        emitByte(8'($random(seed)));
        emitByte(8'($random(seed)));
        flagLoop();
        emitByte(8'($random(seed)));
        emitByte(8'($random(seed)));
        put(encImm(opHlt, 4'd0, 8'h00));
        putIsr();
    endtask

    task automatic buildMask();
        logic [7:0] delayAt;
        clearProg();
        put(encImm(opLdi, 4'd6, 8'h00));
        put(encImm(opSt, 4'd6, 8'h20));
        put(encImm(opLdi, 4'd1, 8'h05));
        put(encImm(opSt, 4'd1, 8'hFE));    // Mask line 1
        put(encImm(opEi, 4'd0, 8'h00));
        emitByte(8'($random(seed)));
        put(encImm(opLdi, 4'd3, 8'd30));
        put(encImm(opLdi, 4'd4, 8'd1));
        delayAt = progPtr;
        put(encReg(opSub, 4'd3, 4'd4));
        put(encImm(opJz, 4'd0, delayAt + 8'd3));
        put(encImm(opJmp, 4'd0, delayAt));
        emitByte(8'($random(seed)));
        put(encImm(opLdi, 4'd1, 8'h07));
        put(encImm(opSt, 4'd1, 8'hFE));    // Unmask, pending line is served
        flagLoop();
        emitByte(8'($random(seed)));
        put(encImm(opHlt, 4'd0, 8'h00));
        putIsr();
    endtask

    task automatic buildHalt();
        clearProg();
        emitByte(8'($random(seed)));
        put(encImm(opHlt, 4'd0, 8'h00));
        emitByte(8'($random(seed)));       // Never reached
        put(encImm(opHlt, 4'd0, 8'h00));
    endtask

    //**********************************************************
    initial begin
        clk = 1'b0;
        rst = 1'b1;
        progWrite = 1'b0;
        progAddr = 16'h0000;
        progData = 16'h0000;
        irqLines = 3'b000;
        testsRun = 0;
        testsFailed = 0;
        expCount = 0;
        for (int i = 0; i < 64; i++) expBytes[6'(i)] = 8'h00;

        buildAlu();
        runTest("alu", -1, 0);
        buildJz();
        runTest("jz", -1, 0);
        buildMem();
        runTest("dmem", -1, 0);
        buildIrq();
        runTest("irq", 0, 2);
        buildMask();
        runTest("mask", 1, 1);
        buildHalt();
        runTest("halt", -1, 0);

        $display("Tests run %0d, passed %0d, failed %0d, check errors %0d",
                 testsRun, testsRun - testsFailed, testsFailed, errorCount);
        if (testsFailed == 0 && errorCount == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== tests/mcuChecker.sv ====
`timescale 1ns/1ps

module mcuChecker (
    input  logic       clk,
    input  logic       rst,
    input  logic       outValid,
    input  logic [7:0] outPort,
    input  logic [7:0] expBytes [64],
    input  int         expCount,
    output int         gotCount,
    output int         errorCount
);
    string testName = "none";     // Set by the testbench before each test
    int    got = 0;
    int    errors = 0;

    assign gotCount   = got;
    assign errorCount = errors;

    //**********************************************************
    // Compare every output strobe against the expected bytes
    always @(posedge clk) begin
        if (rst) begin
            got <= 0;                       // Fresh sequence per test
        end else if (outValid) begin
            if (got >= expCount) begin
                $display("Test %s: unexpected output %02h after the last expected byte",
                         testName, outPort);
                errors <= errors + 1;
            end else if (outPort !== expBytes[6'(got)]) begin
                $display("MISMATCH test %s byte %0d: expected %02h, actual %02h",
                         testName, got, expBytes[6'(got)], outPort);
                errors <= errors + 1;
            end
            got <= got + 1;
        end
    end

endmodule

// ==== tests/mcu_properties.sv ====
`timescale 1ns/1ps

module mcuProperties import cpuPkg::*; (
    input logic clk,
    input logic rst,
    input logic irqReq,
    input logic irqAck,
    input ctrlT ctrl
);
    //**********************************************************
    // Four-phase interrupt handshake
    ackNeedsReq: assert property (@(posedge clk) disable iff (rst)
        $rose(irqAck) |-> irqReq)
        else $error("irqAck rose without a pending irqReq");

    reqWaitsForAck: assert property (@(posedge clk) disable iff (rst)
        $rose(irqReq) |-> !$past(irqAck))
        else $error("irqReq rose while irqAck was still high");

    // Control word stays quiet once reset has taken hold
    quietInReset: assert property (@(posedge clk)
        (rst && $past(rst)) |-> !(ctrl.regWrite || ctrl.dMemWrite || ctrl.dMemRead
                                  || ctrl.pcWrite || ctrl.flagWrite))
        else $error("Control write field active during reset");

endmodule

bind control mcuProperties props (
    .clk(clk), .rst(rst), .irqReq(irqReq), .irqAck(irqAck), .ctrl(ctrl)
);

// ==== design/mcuTop.sv ====
`timescale 1ns/1ps

module mcuTop import cpuPkg::*; #(
    parameter int iMemDepth = 256
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        progWrite,
    input  logic [15:0] progAddr,
    input  logic [15:0] progData,
    input  logic [2:0]  irqLines,
    output logic [7:0]  outPort,
    output logic        outValid,
    output logic        halted
);
    logic [15:0] iMemAddress;
    instrWordT   iMemOut;
    logic [15:0] dMemAddress;
    logic [7:0]  dMemIn;
    logic [7:0]  dMemOut;
    logic        dMemWrite;
    logic        dMemRead;

    cpu core (
        .clk(clk), .rst(rst),
        .iMemAddress(iMemAddress), .iMemOut(iMemOut),
        .dMemAddress(dMemAddress), .dMemIn(dMemIn), .dMemOut(dMemOut),
        .dMemWrite(dMemWrite), .dMemRead(dMemRead),
        .irqLines(irqLines), .halted(halted)
    );

    memorySystem #(.iMemDepth(iMemDepth)) mem (
        .clk(clk), .rst(rst),
        .progWrite(progWrite), .progAddr(progAddr), .progData(progData),
        .iMemAddress(iMemAddress), .iMemOut(iMemOut),
        .dMemAddress(dMemAddress), .dMemIn(dMemIn), .dMemOut(dMemOut),
        .dMemWrite(dMemWrite), .dMemRead(dMemRead),
        .outPort(outPort), .outValid(outValid)
    );

endmodule

// ==== design/memorySystem.sv ====
`timescale 1ns/1ps

module memorySystem import cpuPkg::*; #(
    parameter int iMemDepth = 256
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        progWrite,
    input  logic [15:0] progAddr,
    input  logic [15:0] progData,
    input  logic [15:0] iMemAddress,
    output instrWordT   iMemOut,
    input  logic [15:0] dMemAddress,
    input  logic [7:0]  dMemIn,
    output logic [7:0]  dMemOut,
    input  logic        dMemWrite,
    input  logic        dMemRead,
    output logic [7:0]  outPort,
    output logic        outValid
);
    localparam int iAddrWidth = $clog2(iMemDepth);

    logic [15:0] iMem [iMemDepth];
    logic [7:0]  dMem [256];
    logic        outHit;

    // Program load and synchronous fetch
    always_ff @(posedge clk) begin
        if (progWrite) begin
            iMem[progAddr[iAddrWidth-1:0]] <= progData;
        end
        iMemOut <= iMem[iMemAddress[iAddrWidth-1:0]];
    end

    // I/O page RAM
    always_ff @(posedge clk) begin
        if (dMemWrite) begin
            dMem[dMemAddress[7:0]] <= dMemIn;
        end
        if (dMemRead) begin
            dMemOut <= dMem[dMemAddress[7:0]];
        end
    end

    //**********************************************************
    // Output port
    assign outHit = dMemWrite && (dMemAddress == outPortAddr);

    always_ff @(posedge clk) begin
        if (rst) begin
            outValid <= 1'b0;
        end else begin
            outValid <= outHit;     // One cycle strobe per store
        end
    end

    always_ff @(posedge clk) begin
        if (outHit) begin
            outPort <= dMemIn;
        end
    end

endmodule

// ==== design/cpu.sv ====
`timescale 1ns/1ps

module cpu import cpuPkg::*; (
    input  logic        clk,
    input  logic        rst,
    output logic [15:0] iMemAddress,
    input  instrWordT   iMemOut,
    output logic [15:0] dMemAddress,
    output logic [7:0]  dMemIn,
    input  logic [7:0]  dMemOut,
    output logic        dMemWrite,
    output logic        dMemRead,
    input  logic [2:0]  irqLines,
    output logic        halted
);
    ctrlT        ctrl;
    statusT      status;
    instrWordT   instr;
    logic        irqReq;
    logic        irqAck;
    logic        maskWrite;
    logic [15:0] pc;
    logic [15:0] pcNext;
    logic [15:0] returnShadow;
    logic [7:0]  regIn;
    logic [7:0]  readA;
    logic [7:0]  readB;
    logic [7:0]  aluB;
    logic [7:0]  aluResult;
    logic [2:0]  aluFlags;

    //**********************************************************
    // Blocks
    control cntrl (
        .clk(clk), .rst(rst), .instr(instr), .status(status),
        .irqReq(irqReq), .irqAck(irqAck), .ctrl(ctrl), .halted(halted)
    );

    interruptCtrl intCtrl (
        .clk(clk), .rst(rst), .irqLines(irqLines), .maskWrite(maskWrite),
        .maskData(dMemIn[2:0]), .irqReq(irqReq), .irqAck(irqAck)
    );

    regFile registers (
        .clk(clk), .rst(rst), .writeEn(ctrl.regWrite),
        .writeSel(instr.regForm.rd), .readSelA(instr.regForm.rd),
        .readSelB(instr.regForm.rs), .writeData(regIn),
        .readA(readA), .readB(readB)
    );

    alu aluUnit (
        .dataA(readA), .dataB(aluB), .mode(ctrl.aluMode),
        .result(aluResult), .flags(aluFlags)
    );

    //**********************************************************
    // Source muxes
    assign instr = iMemOut;     // Fetch register still holds LD during writeback

    assign aluB = (ctrl.aluBSel == aluBImm) ? instr.immForm.imm : readB;

    always_comb begin
        case (ctrl.regSrcSel)
            regSrcImm: regIn = instr.immForm.imm;
            regSrcMem: regIn = dMemOut;
            default:   regIn = aluResult;
        endcase
    end

    // Data side stays in the I/O page
    assign dMemAddress = {ioPageBase, aluB};
    assign dMemIn      = readA;             // Store data is rd
    assign dMemWrite   = ctrl.dMemWrite;
    assign dMemRead    = ctrl.dMemRead;
    assign maskWrite   = ctrl.dMemWrite && (dMemAddress == maskAddr);

    //**********************************************************
    // Status register
    always_ff @(posedge clk) begin
        if (rst) begin
            status <= '0;
        end else begin
            if (ctrl.flagWrite) begin
                status.negative <= aluFlags[2];
                status.zero     <= aluFlags[1];
                status.carry    <= aluFlags[0];
            end
            if (ctrl.setIe) begin
                status.interruptEnable <= 1'b1;
            end else if (ctrl.clearIe) begin
                status.interruptEnable <= 1'b0;
            end
        end
    end

    // PC and return shadow
    always_comb begin
        case (ctrl.pcSrcSel)
            pcSrcJump:   pcNext = {8'h00, instr.immForm.imm};
            pcSrcVector: pcNext = irqVector;
            pcSrcReturn: pcNext = returnShadow;
            default:     pcNext = pc + 16'd1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= 16'd0;
        end else if (ctrl.pcWrite) begin
            pc <= pcNext;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.saveReturn) begin
            returnShadow <= pc;
        end
    end

    assign iMemAddress = pc;

endmodule

// ==== design/control.sv ====
`timescale 1ns/1ps

module control import cpuPkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  instrWordT instr,
    input  statusT    status,
    input  logic      irqReq,
    output logic      irqAck,
    output ctrlT      ctrl,
    output logic      halted
);
    localparam logic [2:0] stFetch     = 3'd0;
    localparam logic [2:0] stExecute   = 3'd1;
    localparam logic [2:0] stLoadWb    = 3'd2;
    localparam logic [2:0] stIrqAck    = 3'd3;
    localparam logic [2:0] stIrqVector = 3'd4;
    localparam logic [2:0] stHalt      = 3'd5;

    logic [2:0] state;
    logic [2:0] nextState;
    logic       takeIrq;
    opcodeT     opcode;

    assign opcode  = instr.regForm.opcode;    // Same position in both forms
    assign takeIrq = irqReq && status.interruptEnable && !irqAck;
    assign halted  = (state == stHalt);

    //**********************************************************
    // State and acknowledge registers
    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= stFetch;
            irqAck <= 1'b0;
        end else begin
            state <= nextState;
            if (nextState == stIrqAck) begin
                irqAck <= 1'b1;
            end else if (!irqReq) begin
                irqAck <= 1'b0;     // Requester has let go
            end
        end
    end

    //**********************************************************
    // Decode
    always_comb begin
        ctrl      = '0;
        nextState = state;
        case (state)
            stFetch: begin
                nextState = stExecute;      // Instruction word arrives next cycle
            end
            stExecute: begin
                ctrl.pcWrite  = 1'b1;
                ctrl.pcSrcSel = pcSrcInc;
                nextState     = takeIrq ? stIrqAck : stFetch;
                case (opcode)
                    opAdd, opSub, opAnd, opOr, opXor: begin
                        ctrl.regWrite  = 1'b1;
                        ctrl.regSrcSel = regSrcAlu;
                        ctrl.aluBSel   = aluBReg;
                        ctrl.flagWrite = 1'b1;
                        case (opcode)
                            opSub:   ctrl.aluMode = aluSub;
                            opAnd:   ctrl.aluMode = aluAnd;
                            opOr:    ctrl.aluMode = aluOr;
                            opXor:   ctrl.aluMode = aluXor;
                            default: ctrl.aluMode = aluAdd;
                        endcase
                    end
                    opLdi: begin
                        ctrl.regWrite  = 1'b1;
                        ctrl.regSrcSel = regSrcImm;
                    end
                    opLd: begin
                        ctrl.dMemRead = 1'b1;
                        ctrl.aluBSel  = aluBImm;    // Low address byte from immediate
                        nextState     = stLoadWb;
                    end
                    opSt: begin
                        ctrl.dMemWrite = 1'b1;
                        ctrl.aluBSel   = aluBImm;
                    end
                    opJmp: begin
                        ctrl.pcSrcSel = pcSrcJump;
                    end
                    opJz: begin
                        ctrl.pcSrcSel = status.zero ? pcSrcJump : pcSrcInc;
                    end
                    opEi: begin
                        ctrl.setIe = 1'b1;
                    end
                    opReti: begin
                        ctrl.setIe    = 1'b1;
                        ctrl.pcSrcSel = pcSrcReturn;
                    end
                    opHlt: begin
                        ctrl.pcWrite = 1'b0;
                        nextState    = stHalt;
                    end
                    default: begin
                        // NOP and unused codes just advance
                    end
                endcase
            end
            stLoadWb: begin
                ctrl.regWrite  = 1'b1;
                ctrl.regSrcSel = regSrcMem;
                nextState      = takeIrq ? stIrqAck : stFetch;
            end
            stIrqAck: begin
                ctrl.saveReturn = 1'b1;     // PC already points past the last instruction
                ctrl.clearIe    = 1'b1;
                nextState       = stIrqVector;
            end
            stIrqVector: begin
                ctrl.pcWrite  = 1'b1;
                ctrl.pcSrcSel = pcSrcVector;
                nextState     = stFetch;
            end
            stHalt: begin
                nextState = stHalt;
            end
            default: begin
                nextState = stFetch;
            end
        endcase
    end

endmodule

// ==== design/interruptCtrl.sv ====
`timescale 1ns/1ps

module interruptCtrl (
    input  logic       clk,
    input  logic       rst,
    input  logic [2:0] irqLines,
    input  logic       maskWrite,
    input  logic [2:0] maskData,
    output logic       irqReq,
    input  logic       irqAck
);
    logic [2:0] pending;
    logic [2:0] mask;           // 1 = line enabled
    logic [2:0] linesDly;
    logic [2:0] rise;
    logic [2:0] active;
    logic [2:0] chosen;

    assign rise   = irqLines & ~linesDly;
    assign active = pending & mask;
    assign chosen = active & (~active + 3'd1);  // Lowest numbered line wins

    always_ff @(posedge clk) begin
        if (rst) begin
            pending  <= 3'b000;
            mask     <= 3'b111;
            linesDly <= 3'b000;
            irqReq   <= 1'b0;
        end else begin
            linesDly <= irqLines;
            if (maskWrite) begin
                mask <= maskData;
            end
            if (irqReq && irqAck) begin
                // Acknowledged, retire the serviced line
                irqReq  <= 1'b0;
                pending <= (pending & ~chosen) | rise;
            end else begin
                pending <= pending | rise;
                // New request only once the previous ack has gone low
                if (!irqReq && !irqAck && (|active)) begin
                    irqReq <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== design/regFile.sv ====
`timescale 1ns/1ps

module regFile (
    input  logic       clk,
    input  logic       rst,
    input  logic       writeEn,
    input  logic [3:0] writeSel,
    input  logic [3:0] readSelA,
    input  logic [3:0] readSelB,
    input  logic [7:0] writeData,
    output logic [7:0] readA,
    output logic [7:0] readB
);
    logic [7:0] regs [16];

    // Single write port
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= 8'd0;
            end
        end else if (writeEn) begin
            regs[writeSel] <= writeData;
        end
    end

    // Reads see the old value during a write cycle
    assign readA = regs[readSelA];
    assign readB = regs[readSelB];

endmodule

// ==== design/alu.sv ====
`timescale 1ns/1ps

module alu import cpuPkg::*; (
    input  logic [7:0] dataA,
    input  logic [7:0] dataB,
    input  aluModeT    mode,
    output logic [7:0] result,
    output logic [2:0] flags        // {negative, zero, carry}
);
    logic [8:0] sum;
    logic       carry;

    always_comb begin
        sum    = 9'd0;
        result = 8'd0;
        carry  = 1'b0;
        case (mode)
            aluAdd: begin
                sum    = {1'b0, dataA} + {1'b0, dataB};
                result = sum[7:0];
                carry  = sum[8];
            end
            aluSub: begin
                // Two's complement subtract, carry set means no borrow
                sum    = {1'b0, dataA} + {1'b0, ~dataB} + 9'd1;
                result = sum[7:0];
                carry  = sum[8];
            end
            aluAnd: begin
                result = dataA & dataB;
            end
            aluOr: begin
                result = dataA | dataB;
            end
            aluXor: begin
                result = dataA ^ dataB;
            end
            aluPassB: begin
                result = dataB;
            end
            default: begin
                result = 8'd0;
            end
        endcase
    end

    assign flags = {result[7], (result == 8'd0), carry};

endmodule

// ==== design/cpuPkg.sv ====
package cpuPkg;

    //**********************************************************
    // Instruction set
    typedef enum logic [3:0] {
        opNop  = 4'h0,
        opAdd  = 4'h1,
        opSub  = 4'h2,
        opAnd  = 4'h3,
        opOr   = 4'h4,
        opXor  = 4'h5,
        opLdi  = 4'h6,
        opLd   = 4'h7,
        opSt   = 4'h8,
        opJmp  = 4'h9,
        opJz   = 4'hA,
        opEi   = 4'hB,
        opReti = 4'hC,
        opHlt  = 4'hD
    } opcodeT;

    typedef struct packed {
        opcodeT     opcode;
        logic [3:0] rd;
        logic [3:0] rs;
        logic [3:0] spare;      // Reserved, ignored by decode
    } regFormT;

    typedef struct packed {
        opcodeT     opcode;
        logic [3:0] rd;
        logic [7:0] imm;
    } immFormT;

    // ALU ops use regForm, everything with a constant uses immForm
    typedef union packed {
        regFormT regForm;
        immFormT immForm;
    } instrWordT;

    //**********************************************************
    // Datapath state and control word
    typedef struct packed {
        logic interruptEnable;
        logic negative;
        logic zero;
        logic carry;
    } statusT;

    typedef enum logic [2:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor, aluPassB
    } aluModeT;

    typedef struct packed {
        logic       regWrite;
        logic [1:0] regSrcSel;
        aluModeT    aluMode;
        logic       aluBSel;
        logic       flagWrite;
        logic       dMemWrite;
        logic       dMemRead;
        logic       pcWrite;
        logic [1:0] pcSrcSel;
        logic       saveReturn;
        logic       setIe;
        logic       clearIe;
    } ctrlT;

    // Register write source
    localparam logic [1:0] regSrcAlu = 2'd0;
    localparam logic [1:0] regSrcImm = 2'd1;
    localparam logic [1:0] regSrcMem = 2'd2;

    // ALU operand B
    localparam logic aluBReg = 1'b0;
    localparam logic aluBImm = 1'b1;

    // Next PC source
    localparam logic [1:0] pcSrcInc    = 2'd0;
    localparam logic [1:0] pcSrcJump   = 2'd1;
    localparam logic [1:0] pcSrcVector = 2'd2;
    localparam logic [1:0] pcSrcReturn = 2'd3;

    //**********************************************************
    // Memory map
    localparam logic [7:0]  ioPageBase  = 8'h10;
    localparam logic [15:0] outPortAddr = 16'h10FF;
    localparam logic [15:0] maskAddr    = 16'h10FE;
    localparam logic [15:0] irqVector   = 16'h00F0;

endpackage
